//--- verification/cpu_trace.txt
# T name | P program bytes | D data address value pairs | S expected store address data pairs
# All values are two hex digits. Stores are listed in program order.
T li_alu
P 15 29 64 31 b9 29 65 32 b9 29 66 33 b9
P 29 67 34 b9 23 65 35 b9 c0
S 01 0e 02 04 03 0c 04 01 05 fe
T load_alu
P 08 90 09 a0 58 3a b5 66 3b b9 8c 1c 91 c0
D 08 2a 09 13
S 0a 3d 0b 2e 0c 2e
T waw_rename
P 03 07 11 44 22 a1 0f 06 45 33 b1 40 34 b1 c0
S 02 08 03 05 04 0a
T arb_stall
P 05 26 14 b0 54 88 66 9d a1 70 0f 8d c0
D 05 40 06 21
S 08 40 0e 21 0f 61
T free_recycle
P 01 40 40 40 40 40 40 40 19 91 40 2a a1 31 4d 2b a1 c0
S 09 80 0a 00 0b ff
T halt_stop
P 02 17 85 c0 85 85
S 02 07

//--- sources.f
hw/ooo_pkg.sv
hw/rename_frontend.sv
hw/alu_pipe.sv
hw/mem_pipe.sv
hw/result_arbiter.sv
hw/reorder_buffer.sv
hw/cpu_ooo.sv
verification/tb_cpu_ooo.sv

//--- Bender.yml
package:
  name: cpu_ooo

sources:
  - hw/ooo_pkg.sv
  - hw/rename_frontend.sv
  - hw/alu_pipe.sv
  - hw/mem_pipe.sv
  - hw/result_arbiter.sv
  - hw/reorder_buffer.sv
  - hw/cpu_ooo.sv
  - target: test
    files:
      - verification/tb_cpu_ooo.sv

//--- verification/tb_cpu_ooo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_ooo import ooo_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic [15:0] addr_i;
    logic [7:0]  din_i;
    logic [15:0] addr_d;
    logic [7:0]  dout_d;
    logic        wr_d;
    logic [7:0]  din_d;
    logic        halted;

    logic [7:0]  prog_mem [256];
    logic [7:0]  data_mem [256];

    // Trace contents. Each test owns the slice from its first index to the next test's.
    logic [8*24-1:0] names [16];
    int              p_first [17];
    int              d_first [17];
    int              s_first [17];
    logic [7:0]      p_byte [512];
    logic [15:0]     d_pair [512];
    logic [15:0]     s_pair [512];
    int              n_tests;
    int              n_prog;
    int              n_data;
    int              n_store;

    int s_next;
    int s_end;
    int late_stores;
    int errors;
    int n_pass;
    int n_fail;
    int limit_ns;

    cpu_ooo dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .addr_i(addr_i),
        .din_i (din_i),
        .addr_d(addr_d),
        .dout_d(dout_d),
        .wr_d  (wr_d),
        .din_d (din_d),
        .halted(halted)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check_store(input logic [7:0] addr, input logic [data_w-1:0] data);
        if (s_next >= s_end) begin
            $display("ERROR t=%0t unexpected store of %02h to address %02h", $time, data, addr);
            errors++;
        end else begin
            if (addr !== s_pair[s_next][15:8]) begin
                $display("MISMATCH t=%0t addr_d got %02h expected %02h",
                         $time, addr, s_pair[s_next][15:8]);
                errors++;
            end
            if (data !== s_pair[s_next][7:0]) begin
                $display("MISMATCH t=%0t dout_d got %02h expected %02h",
                         $time, data, s_pair[s_next][7:0]);
                errors++;
            end
            s_next++;
        end
    endtask

    // Both address ports carry an 8-bit address zero-extended to 16 bits.
    task automatic check_addr_high(input string name, input logic [15:0] addr);
        if (addr[15:8] !== 8'h00) begin
            $display("MISMATCH t=%0t %0s[15:8] got %02h expected 00",
                     $time, name, addr[15:8]);
            errors++;
        end
    endtask

    task automatic check_halt(input logic halt_level, input int late);
        if (halt_level !== 1'b1) begin
            $display("ERROR t=%0t halted dropped after it was raised", $time);
            errors++;
        end
        if (s_next < s_end) begin
            $display("ERROR t=%0t core halted with %0d stores still expected",
                     $time, s_end - s_next);
            errors++;
        end
        if (late != 0) begin
            $display("ERROR t=%0t %0d stores happened after halted", $time, late);
            errors++;
        end
    endtask

    // Both memories answer one cycle after the address, like synchronous RAMs.
    task automatic step_clock();
        @(posedge clk);
        din_i <= prog_mem[addr_i[7:0]];
        din_d <= data_mem[addr_d[7:0]];
        if (rst_n) begin
            check_addr_high("addr_i", addr_i);
        end
        if (rst_n && wr_d) begin
            check_addr_high("addr_d", addr_d);
            if (halted) begin
                late_stores++;
            end else begin
                check_store(addr_d[7:0], dout_d);
            end
            data_mem[addr_d[7:0]] = dout_d;
        end
    endtask

    task automatic reset_core();
        rst_n <= 1'b0;
        repeat (5) step_clock();
        rst_n <= 1'b1;
    endtask

    task automatic load_trace(input int fd);
        logic [8*32-1:0]  tok;
        logic [8*128-1:0] rest;
        logic [7:0]       kind;
        logic [7:0]       val;
        logic [7:0]       hold;
        logic             half;
        int               n;
        kind = "P";
        half = 1'b0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(rest, fd);
            end else if (tok == "T") begin
                n = $fscanf(fd, "%s", names[n_tests]);
                p_first[n_tests] = n_prog;
                d_first[n_tests] = n_data;
                s_first[n_tests] = n_store;
                n_tests++;
            end else if (tok[8*32-1:8] == '0) begin
                kind = tok[7:0];
                half = 1'b0;
            end else begin
                n = $sscanf(tok, "%h", val);
                if (kind == "P") begin
                    p_byte[n_prog] = val;
                    n_prog++;
                end else if (!half) begin
                    hold = val;
                    half = 1'b1;
                end else if (kind == "D") begin
                    d_pair[n_data] = {hold, val};
                    n_data++;
                    half = 1'b0;
                end else begin
                    s_pair[n_store] = {hold, val};
                    n_store++;
                    half = 1'b0;
                end
            end
        end
        p_first[n_tests] = n_prog;
        d_first[n_tests] = n_data;
        s_first[n_tests] = n_store;
    endtask

    task automatic run_test(input int t);
        int errs_before;
        errs_before = errors;
        for (int i = 0; i < 256; i++) begin
            // Unused program space decodes as HALT.
            prog_mem[i] = 8'hc0 | ((8'(i) ^ 8'(i >> 2)) & 8'h3f);
            data_mem[i] = 8'(i) ^ 8'ha5;
        end
        for (int i = p_first[t]; i < p_first[t + 1]; i++) begin
            prog_mem[i - p_first[t]] = p_byte[i];
        end
        for (int i = d_first[t]; i < d_first[t + 1]; i++) begin
            data_mem[d_pair[i][15:8]] = d_pair[i][7:0];
        end
        s_next      = s_first[t];
        s_end       = s_first[t + 1];
        late_stores = 0;
        reset_core();
        while (!halted) begin
            step_clock();
        end
        // Keep running a little so a store after halt would be seen.
        repeat (8) step_clock();
        check_halt(halted, late_stores);
        if (errors == errs_before) begin
            n_pass++;
            $display("test %0s: ok", names[t]);
        end else begin
            n_fail++;
            $display("test %0s: %0d errors", names[t], errors - errs_before);
        end
    endtask

    initial begin
        int fd;
        rst_n = 1'b0;
        din_i = '0;
        din_d = '0;
        fd = $fopen("verification/cpu_trace.txt", "r");
        if (fd == 0) begin
            $display("ERROR could not open verification/cpu_trace.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            load_trace(fd);
            $fclose(fd);
            limit_ns = n_prog * 40 * 8;
            for (int t = 0; t < n_tests; t++) begin
                run_test(t);
            end
            $display("passing tests %0d, failing tests %0d", n_pass, n_fail);
            if (errors == 0 && n_fail == 0 && n_tests > 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("ERROR watchdog expired after %0d ns, the core never halted", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/cpu_ooo.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ooo import ooo_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    output logic [15:0] addr_i,
    input  logic [7:0]  din_i,

    output logic [15:0] addr_d,
    output logic [7:0]  dout_d,
    output logic        wr_d,
    input  logic [7:0]  din_d,

    output logic        halted
);

    uop_t                 alu_uop;
    uop_t                 mem_uop;
    logic                 alu_issue;
    logic                 mem_issue;
    logic                 rob_alloc;
    rob_entry_t           rob_entry;
    result_t              alu_result;
    result_t              mem_result;
    result_t              wb;
    logic                 alu_stall;
    logic [rob_idx_w-1:0] rob_tail;
    logic                 rob_full;
    logic                 free_phys_valid;
    logic [pr_addr_w-1:0] free_phys;

    rename_frontend _frontend (
        .clk            (clk),
        .rst_n          (rst_n),
        .addr_i         (addr_i),
        .din_i          (din_i),
        .wb             (wb),
        .free_phys_valid(free_phys_valid),
        .free_phys      (free_phys),
        .rob_full       (rob_full),
        .alu_stall      (alu_stall),
        .rob_tail       (rob_tail),
        .halted         (halted),
        .alu_uop        (alu_uop),
        .mem_uop        (mem_uop),
        .alu_issue      (alu_issue),
        .mem_issue      (mem_issue),
        .rob_alloc      (rob_alloc),
        .rob_entry      (rob_entry)
    );

    alu_pipe _alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_issue (alu_issue),
        .alu_uop   (alu_uop),
        .alu_stall (alu_stall),
        .alu_result(alu_result)
    );

    mem_pipe _mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_issue (mem_issue),
        .mem_uop   (mem_uop),
        .din_d     (din_d),
        .addr_d    (addr_d),
        .dout_d    (dout_d),
        .wr_d      (wr_d),
        .mem_result(mem_result)
    );

    result_arbiter _arb (
        .alu_result(alu_result),
        .mem_result(mem_result),
        .wb        (wb),
        .alu_stall (alu_stall)
    );

    reorder_buffer _rob (
        .clk            (clk),
        .rst_n          (rst_n),
        .rob_alloc      (rob_alloc),
        .rob_entry      (rob_entry),
        .wb             (wb),
        .rob_tail       (rob_tail),
        .rob_full       (rob_full),
        .free_phys_valid(free_phys_valid),
        .free_phys      (free_phys),
        .halted         (halted)
    );

endmodule

`default_nettype wire

//--- hw/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rob_alloc,
    input  rob_entry_t            rob_entry,
    input  result_t               wb,
    output logic [rob_idx_w-1:0]  rob_tail,
    output logic                  rob_full,
    output logic                  free_phys_valid,
    output logic [pr_addr_w-1:0]  free_phys,
    output logic                  halted
);

    rob_entry_t             entries [rob_depth];
    logic [rob_idx_w-1:0]   head;
    logic [rob_idx_w-1:0]   tail;
    logic [rob_idx_w:0]     count;
    logic                   retire;
    logic [rob_idx_w-1:0]   wb_offset;
    rob_entry_t             head_entry;

    assign head_entry = entries[head];
    assign retire     = (count != '0) && head_entry.done;

    assign rob_tail        = tail;
    assign rob_full        = (count == (rob_idx_w + 1)'(rob_depth));
    assign free_phys_valid = retire && head_entry.has_dest;
    assign free_phys       = head_entry.old_phys;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            halted <= 1'b0;
        end else begin
            if (rob_alloc) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
                if (head_entry.is_halt) begin
                    halted <= 1'b1;
                end
            end
            count <= count + (rob_idx_w + 1)'(rob_alloc) - (rob_idx_w + 1)'(retire);
        end
    end

    // Allocation fills the tail slot and the result bus marks its slot done.
    always_ff @(posedge clk) begin
        if (rob_alloc) begin
            entries[tail] <= rob_entry;
        end
        if (wb.valid) begin
            entries[wb.rob_idx].done <= 1'b1;
        end
    end

    assign wb_offset = wb.rob_idx - head;

    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        rob_alloc |-> !rob_full);

    a_complete_live: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> (({1'b0, wb_offset} < count) && !entries[wb.rob_idx].done));

endmodule

`default_nettype wire

//--- hw/result_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module result_arbiter import ooo_pkg::*; (
    input  result_t alu_result,
    input  result_t mem_result,
    output result_t wb,
    output logic    alu_stall
);

    // The memory pipe cannot hold its result, so it always has priority.
    always_comb begin
        if (mem_result.valid) begin
            wb = mem_result;
        end else begin
            wb = alu_result;
        end
    end

    assign alu_stall = mem_result.valid && alu_result.valid;

    // Two results that meet at the bus always belong to different instructions.
    always_comb begin
        a_distinct_results: assert final (!alu_stall
            || (alu_result.rob_idx != mem_result.rob_idx));
    end

endmodule

`default_nettype wire

//--- hw/mem_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mem_pipe import ooo_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_issue,
    input  uop_t              mem_uop,
    input  logic [7:0]        din_d,
    output logic [15:0]       addr_d,
    output logic [7:0]        dout_d,
    output logic              wr_d,
    output result_t           mem_result
);

    logic s1_valid;
    uop_t s1_uop;
    logic s2_valid;
    uop_t s2_uop;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= mem_issue;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_uop <= mem_uop;
        s2_uop <= s1_uop;
    end

    // Stores take the address from rd, loads from rs.
    assign addr_d = {8'h00, s1_uop.is_store ? s1_uop.a : s1_uop.b};
    assign dout_d = s1_uop.b;
    assign wr_d   = s1_valid && s1_uop.is_store;

    // Load data comes back from the synchronous memory during stage two.
    always_comb begin
        mem_result.valid     = s2_valid;
        mem_result.dest_phys = s2_uop.dest_phys;
        mem_result.has_dest  = s2_uop.has_dest;
        mem_result.data      = s2_uop.is_store ? s2_uop.b : din_d;
        mem_result.rob_idx   = s2_uop.rob_idx;
    end

endmodule

`default_nettype wire

//--- hw/alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    alu_issue,
    input  uop_t    alu_uop,
    input  logic    alu_stall,
    output result_t alu_result
);

    logic [data_w-1:0] alu_out;
    result_t           res_q;

    always_comb begin
        if (alu_uop.opcode == op_li) begin
            alu_out = alu_uop.b;
        end else begin
            case (alu_uop.alu_fn)
                fn_add:  alu_out = alu_uop.a + alu_uop.b;
                fn_sub:  alu_out = alu_uop.a - alu_uop.b;
                fn_xor:  alu_out = alu_uop.a ^ alu_uop.b;
                fn_and:  alu_out = alu_uop.a & alu_uop.b;
                default: alu_out = '0;
            endcase
        end
    end

    // While the bus is denied the held result stays put.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_q.valid <= 1'b0;
        end else if (!alu_stall) begin
            res_q.valid     <= alu_issue;
            res_q.dest_phys <= alu_uop.dest_phys;
            res_q.has_dest  <= alu_uop.has_dest;
            res_q.data      <= alu_out;
            res_q.rob_idx   <= alu_uop.rob_idx;
        end
    end

    assign alu_result = res_q;

    a_no_issue_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        alu_issue |-> !alu_stall);

endmodule

`default_nettype wire

//--- hw/rename_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module rename_frontend import ooo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    output logic [15:0]           addr_i,
    input  logic [7:0]            din_i,

    input  result_t               wb,
    input  logic                  free_phys_valid,
    input  logic [pr_addr_w-1:0]  free_phys,
    input  logic                  rob_full,
    input  logic                  alu_stall,
    input  logic [rob_idx_w-1:0]  rob_tail,
    input  logic                  halted,

    output uop_t                  alu_uop,
    output uop_t                  mem_uop,
    output logic                  alu_issue,
    output logic                  mem_issue,
    output logic                  rob_alloc,
    output rob_entry_t            rob_entry
);

    logic [7:0] pc;
    logic [7:0] pc_prev;
    logic       req_valid;
    logic       fetch_stop;
    logic [7:0] ir;
    logic       ir_valid;
    logic       ir_free;
    logic       take;

    opcode_e                      ir_op;
    logic [$clog2(arch_regs)-1:0] rd;
    logic [$clog2(arch_regs)-1:0] rs;
    logic [pr_addr_w-1:0]         rd_phys;
    logic [pr_addr_w-1:0]         rs_phys;
    logic [pr_addr_w-1:0]         alloc_phys;
    logic                         free_avail;
    logic                         need_rd;
    logic                         need_rs;
    logic                         has_dest;
    logic                         to_alu;
    logic                         srcs_ready;
    logic                         issue;

    logic [phys_regs-1:0] free_list;
    logic [phys_regs-1:0] ready_sb;
    logic [pr_addr_w-1:0] rename_map [arch_regs];
    logic [data_w-1:0]    prf [phys_regs];
    uop_t                 uop;

    assign addr_i  = {8'h00, pc};
    assign ir_free = !ir_valid || issue;
    assign take    = req_valid && ir_free;

    // Fetch runs one address ahead. A byte that arrives while the fetch
    // register is busy is dropped and its address is requested again.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= 8'h00;
            req_valid  <= 1'b0;
            fetch_stop <= 1'b0;
            ir_valid   <= 1'b0;
        end else begin
            if (take) begin
                ir       <= din_i;
                ir_valid <= 1'b1;
            end else if (issue) begin
                ir_valid <= 1'b0;
            end

            if (fetch_stop || halted) begin
                req_valid <= 1'b0;
            end else if (take && opcode_e'(din_i[7:6]) == op_halt) begin
                fetch_stop <= 1'b1;
                req_valid  <= 1'b0;
            end else if (req_valid && !ir_free) begin
                pc        <= pc_prev;
                req_valid <= 1'b0;
            end else begin
                pc_prev   <= pc;
                pc        <= pc + 8'd1;
                req_valid <= 1'b1;
            end
        end
    end

    assign ir_op   = opcode_e'(ir[7:6]);
    assign rd      = ir[5:4];
    assign rs      = ir[3:2];
    assign rd_phys = rename_map[rd];
    assign rs_phys = rename_map[rs];

    // A store reads both registers, a load only the address in rs.
    assign need_rd  = (ir_op == op_alu) || (ir_op == op_mem && ir[0]);
    assign need_rs  = (ir_op == op_alu) || (ir_op == op_mem);
    assign has_dest = (ir_op == op_li) || (ir_op == op_alu) || (ir_op == op_mem && !ir[0]);
    assign to_alu   = (ir_op == op_li) || (ir_op == op_alu);

    // Lowest numbered free register wins.
    always_comb begin
        alloc_phys = '0;
        free_avail = 1'b0;
        for (int i = phys_regs - 1; i >= 0; i--) begin
            if (free_list[i]) begin
                alloc_phys = pr_addr_w'(i);
                free_avail = 1'b1;
            end
        end
    end

    assign srcs_ready = (!need_rd || ready_sb[rd_phys]) && (!need_rs || ready_sb[rs_phys]);

    assign issue = ir_valid && !rob_full && srcs_ready
                   && (!has_dest || free_avail) && !(to_alu && alu_stall);

    always_comb begin
        uop.opcode    = ir_op;
        uop.alu_fn    = alu_fn_e'(ir[1:0]);
        uop.is_store  = ir[0];
        uop.a         = prf[rd_phys];
        uop.b         = (ir_op == op_li) ? {4'h0, ir[3:0]} : prf[rs_phys];
        uop.dest_phys = alloc_phys;
        uop.has_dest  = has_dest;
        uop.rob_idx   = rob_tail;
    end

    assign alu_uop   = uop;
    assign mem_uop   = uop;
    assign alu_issue = issue && to_alu;
    assign mem_issue = issue && (ir_op == op_mem);
    assign rob_alloc = issue;

    // HALT goes into the reorder buffer already complete.
    assign rob_entry = '{old_phys: rd_phys, has_dest: has_dest,
                         is_halt: (ir_op == op_halt), done: (ir_op == op_halt)};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_list <= 8'hf0;
            ready_sb  <= '1;
            for (int i = 0; i < arch_regs; i++) begin
                rename_map[i] <= pr_addr_w'(i);
            end
            for (int i = 0; i < phys_regs; i++) begin
                prf[i] <= '0;
            end
        end else begin
            if (issue && has_dest) begin
                rename_map[rd]       <= alloc_phys;
                free_list[alloc_phys] <= 1'b0;
                ready_sb[alloc_phys]  <= 1'b0;
            end
            if (free_phys_valid) begin
                free_list[free_phys] <= 1'b1;
            end
            if (wb.valid && wb.has_dest) begin
                prf[wb.dest_phys]      <= wb.data;
                ready_sb[wb.dest_phys] <= 1'b1;
            end
        end
    end

    // A register handed out must have been freed and its last writer completed.
    a_alloc_is_free: assert property (@(posedge clk) disable iff (!rst_n)
        (rob_alloc && has_dest) |-> (free_list[alloc_phys] && ready_sb[alloc_phys]));

endmodule

`default_nettype wire

//--- hw/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int arch_regs = 4;
    localparam int phys_regs = 8;
    localparam int pr_addr_w = 3;
    localparam int rob_depth = 8;
    localparam int rob_idx_w = 3;
    localparam int data_w    = 8;

    // Top two bits of every instruction byte.
    typedef enum logic [1:0] {
        op_li   = 2'b00,
        op_alu  = 2'b01,
        op_mem  = 2'b10,
        op_halt = 2'b11
    } opcode_e;

    typedef enum logic [1:0] {
        fn_add = 2'b00,
        fn_sub = 2'b01,
        fn_xor = 2'b10,
        fn_and = 2'b11
    } alu_fn_e;

    // Operand a holds the value of rd and operand b the value of rs,
    // except for LI where b carries the zero-extended immediate.
    typedef struct packed {
        opcode_e               opcode;
        alu_fn_e               alu_fn;
        logic                  is_store;
        logic [data_w-1:0]     a;
        logic [data_w-1:0]     b;
        logic [pr_addr_w-1:0]  dest_phys;
        logic                  has_dest;
        logic [rob_idx_w-1:0]  rob_idx;
    } uop_t;

    typedef struct packed {
        logic                  valid;
        logic [pr_addr_w-1:0]  dest_phys;
        logic                  has_dest;
        logic [data_w-1:0]     data;
        logic [rob_idx_w-1:0]  rob_idx;
    } result_t;

    typedef struct packed {
        logic [pr_addr_w-1:0]  old_phys;
        logic                  has_dest;
        logic                  is_halt;
        logic                  done;
    } rob_entry_t;

endpackage

`default_nettype wire
